/* verilog.f */
gpu_ib_pkg.sv
ib_warp_slot.sv
ib_scoreboard.sv
ib_issue_arbiter.sv
ib_issue_stage.sv
instr_buffer.sv
tb_instr_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the instruction buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=tb_instr_buffer

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* tb_instr_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_instr_buffer
    import gpu_ib_pkg::*;
;

    localparam int NUM_WARPS      = 4;
    localparam int WARP_ID_W      = 2;
    // six tests of up to about 300 cycles each plus margin
    localparam int TIMEOUT_CYCLES = 6 * 300 + 200;
    localparam logic [REG_ID_W:0] NO_REG = '0;

    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        logic [REG_ID_W:0]  src1;
        logic [REG_ID_W:0]  src2;
        logic [REG_ID_W:0]  dst;
        alu_op_e            op;
        logic [IMM_W-1:0]   imm;
        logic               regwrite;
    } entry_t;

    logic                 clk;
    logic                 reset;
    logic                 dec_valid;
    logic [WARP_ID_W-1:0] dec_warp_id;
    logic [INSTR_W-1:0]   dec_instr;
    logic [REG_ID_W:0]    dec_src1;
    logic [REG_ID_W:0]    dec_src2;
    logic [REG_ID_W:0]    dec_dst;
    alu_op_e              dec_alu_op;
    logic [IMM_W-1:0]     dec_imm;
    logic                 dec_regwrite;
    logic                 dec_exit;
    logic [NUM_WARPS-1:0] fetch_req;
    logic [NUM_WARPS-1:0] drop;
    logic                 wb_valid;
    logic [WARP_ID_W-1:0] wb_warp_id;
    logic [REG_ID_W-1:0]  wb_reg;
    logic                 oc_stall;
    logic                 oc_valid;
    logic [WARP_ID_W-1:0] oc_warp_id;
    logic [INSTR_W-1:0]   oc_instr;
    logic [REG_ID_W:0]    oc_src1;
    logic [REG_ID_W:0]    oc_src2;
    logic [REG_ID_W:0]    oc_dst;
    alu_op_e              oc_alu_op;
    logic [IMM_W-1:0]     oc_imm;
    logic                 oc_regwrite;
    logic                 rau_exit;
    logic [WARP_ID_W-1:0] rau_exit_warp_id;

    // reference model with one queue of expected issues per warp
    entry_t               exp_q [NUM_WARPS][$];
    entry_t               last_written;
    logic [WARP_ID_W-1:0] seen_ids [$];
    integer               seed;
    int                   err_count = 0;
    int                   failed_tests = 0;
    int                   beat_count = 0;
    int                   exit_count = 0;
    int                   last_issue_id = NUM_WARPS - 1;
    int                   cycle_count = 0;

    instr_buffer #(
        .NUM_WARPS (NUM_WARPS),
        .WARP_ID_W (WARP_ID_W)
    ) u_instr_buffer (
        .clk              (clk),
        .reset            (reset),
        .dec_valid        (dec_valid),
        .dec_warp_id      (dec_warp_id),
        .dec_instr        (dec_instr),
        .dec_src1         (dec_src1),
        .dec_src2         (dec_src2),
        .dec_dst          (dec_dst),
        .dec_alu_op       (dec_alu_op),
        .dec_imm          (dec_imm),
        .dec_regwrite     (dec_regwrite),
        .dec_exit         (dec_exit),
        .fetch_req        (fetch_req),
        .drop             (drop),
        .wb_valid         (wb_valid),
        .wb_warp_id       (wb_warp_id),
        .wb_reg           (wb_reg),
        .oc_stall         (oc_stall),
        .oc_valid         (oc_valid),
        .oc_warp_id       (oc_warp_id),
        .oc_instr         (oc_instr),
        .oc_src1          (oc_src1),
        .oc_src2          (oc_src2),
        .oc_dst           (oc_dst),
        .oc_alu_op        (oc_alu_op),
        .oc_imm           (oc_imm),
        .oc_regwrite      (oc_regwrite),
        .rau_exit         (rau_exit),
        .rau_exit_warp_id (rau_exit_warp_id)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    //////////////////////////////////////////////////
    // output monitor sampled on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        entry_t got;
        entry_t exp;
        if (!reset && oc_valid === 1'b1) begin
            got.instr    = oc_instr;
            got.src1     = oc_src1;
            got.src2     = oc_src2;
            got.dst      = oc_dst;
            got.op       = oc_alu_op;
            got.imm      = oc_imm;
            got.regwrite = oc_regwrite;
            assert (exp_q[oc_warp_id].size() != 0) else
                report_problem($sformatf("warp %0d issued an instruction that was never queued",
                                         oc_warp_id));
            if (exp_q[oc_warp_id].size() != 0) begin
                exp = exp_q[oc_warp_id].pop_front();
                assert (got == exp) else
                    report_mismatch($sformatf("warp %0d issued %h, expected %h",
                                              oc_warp_id, got, exp));
            end
            seen_ids.push_back(oc_warp_id);
            last_issue_id = int'(oc_warp_id);
            beat_count++;
        end
        if (!reset && rau_exit === 1'b1) begin
            exit_count++;
        end
    end

    function automatic logic [REG_ID_W:0] valid_reg(input int r);
        return {1'b1, REG_ID_W'(r)};
    endfunction

    // called on a falling edge and returns on the next one
    task automatic write_instr(input int warp, input logic [REG_ID_W:0] src1,
                               input logic [REG_ID_W:0] src2, input logic [REG_ID_W:0] dst,
                               input logic regwrite, input logic is_exit);
        entry_t e;
        while (!fetch_req[warp]) @(negedge clk);
        e.instr    = $random(seed);
        e.imm      = IMM_W'($random(seed));
        e.op       = alu_op_e'(4'($unsigned($random(seed)) % 9));
        e.src1     = src1;
        e.src2     = src2;
        e.dst      = dst;
        e.regwrite = regwrite;
        dec_valid    = 1'b1;
        dec_warp_id  = WARP_ID_W'(warp);
        dec_instr    = e.instr;
        dec_src1     = e.src1;
        dec_src2     = e.src2;
        dec_dst      = e.dst;
        dec_alu_op   = e.op;
        dec_imm      = e.imm;
        dec_regwrite = e.regwrite;
        dec_exit     = is_exit;
        // exit entries never reach the operand collector
        if (!is_exit) begin
            exp_q[warp].push_back(e);
        end
        last_written = e;
        @(negedge clk);
        dec_valid = 1'b0;
        dec_exit  = 1'b0;
    endtask

    // random sources and no destination so no scoreboard hit
    task automatic write_independent(input int warp);
        logic [REG_ID_W:0] s1;
        logic [REG_ID_W:0] s2;
        s1 = valid_reg(int'(REG_ID_W'($unsigned($random(seed)))));
        s2 = valid_reg(int'(REG_ID_W'($unsigned($random(seed)))));
        write_instr(warp, s1, s2, NO_REG, 1'b0, 1'b0);
    endtask

    task automatic wait_all_drained();
        int busy;
        busy = 1;
        while (busy != 0) begin
            @(negedge clk);
            busy = 0;
            for (int w = 0; w < NUM_WARPS; w++) begin
                busy += exp_q[w].size();
            end
        end
    endtask

    task automatic print_test_result(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
            failed_tests++;
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic reset_state_check();
        int errs;
        errs = err_count;
        assert (oc_valid == 1'b0 && rau_exit == 1'b0) else
            report_mismatch("oc_valid or rau_exit high after reset");
        assert (fetch_req == '1) else
            report_mismatch($sformatf("fetch_req %b after reset, expected all ones", fetch_req));
        print_test_result("reset state", errs);
    endtask

    task automatic single_warp_flow();
        int     errs;
        entry_t first;
        errs = err_count;
        write_independent(2);
        first = last_written;
        write_independent(2);
        // two edges after the first write
        assert (oc_valid && oc_warp_id == 2'd2 && oc_instr == first.instr) else
            report_mismatch("first instruction of warp 2 not issued two edges after its write");
        oc_stall = 1'b1;
        write_independent(2);
        assert (fetch_req[2] == 1'b0) else
            report_mismatch("fetch_req[2] still high with two entries queued");
        oc_stall = 1'b0;
        while (exp_q[2].size() != 0) @(negedge clk);
        assert (fetch_req[2] == 1'b1) else
            report_mismatch("fetch_req[2] low after the queue drained");
        print_test_result("single warp flow", errs);
    endtask

    task automatic round_robin_order();
        int errs;
        int start;
        errs = err_count;
        oc_stall = 1'b1;
        for (int w = 0; w < NUM_WARPS; w++) begin
            write_independent(w);
            write_independent(w);
        end
        seen_ids.delete();
        start = (last_issue_id + 1) % NUM_WARPS;
        oc_stall = 1'b0;
        while (seen_ids.size() < 2 * NUM_WARPS) @(negedge clk);
        for (int i = 0; i < 2 * NUM_WARPS; i++) begin
            assert (int'(seen_ids[i]) == (start + i) % NUM_WARPS) else
                report_mismatch($sformatf("issue %0d went to warp %0d, expected warp %0d",
                                          i, seen_ids[i], (start + i) % NUM_WARPS));
        end
        wait_all_drained();
        print_test_result("round robin", errs);
    endtask

    task automatic dependency_hold();
        int     errs;
        entry_t reader;
        errs = err_count;
        write_instr(1, NO_REG, NO_REG, valid_reg(5), 1'b1, 1'b0);
        write_instr(1, valid_reg(5), NO_REG, NO_REG, 1'b0, 1'b0);
        reader = last_written;
        repeat (10) @(negedge clk);
        assert (exp_q[1].size() == 1 && exp_q[1][0].instr == reader.instr) else
            report_mismatch("reader of r5 issued while r5 was pending");
        wb_valid   = 1'b1;
        wb_warp_id = 2'd1;
        wb_reg     = 5'd5;
        @(negedge clk);
        wb_valid = 1'b0;
        while (exp_q[1].size() != 0) @(negedge clk);
        print_test_result("dependency", errs);
    endtask

    task automatic stall_and_drop();
        int errs;
        int beats;
        errs = err_count;
        beats = beat_count;
        oc_stall = 1'b1;
        write_independent(0);
        write_independent(3);
        write_independent(3);
        write_independent(1);
        repeat (5) @(negedge clk);
        assert (beat_count == beats) else
            report_mismatch("oc_valid seen while oc_stall was high");
        drop = 4'b1000;
        exp_q[3].delete();
        @(negedge clk);
        drop = '0;
        assert (fetch_req[3] == 1'b1) else
            report_mismatch("fetch_req[3] low after drop");
        oc_stall = 1'b0;
        wait_all_drained();
        repeat (5) @(negedge clk);
        assert (beat_count == beats + 2) else
            report_mismatch($sformatf("%0d issues after release, expected 2", beat_count - beats));
        print_test_result("stall and drop", errs);
    endtask

    task automatic exit_retire();
        int errs;
        int beats;
        int exits;
        errs = err_count;
        beats = beat_count;
        exits = exit_count;
        write_instr(0, NO_REG, NO_REG, NO_REG, 1'b0, 1'b1);
        @(negedge clk);
        assert (rau_exit && rau_exit_warp_id == 2'd0) else
            report_mismatch("no rau_exit for warp 0 two edges after the exit write");
        repeat (5) @(negedge clk);
        assert (exit_count == exits + 1) else
            report_mismatch($sformatf("%0d rau_exit pulses, expected 1", exit_count - exits));
        assert (beat_count == beats) else
            report_mismatch("exit entry showed up on the operand collector side");
        assert (fetch_req[0] == 1'b0) else
            report_mismatch("fetch_req[0] high after warp 0 exited");
        print_test_result("exit", errs);
    endtask

    initial begin
        seed         = 32'h67a9_9ef4;
        reset        = 1'b1;
        dec_valid    = 1'b0;
        dec_warp_id  = '0;
        dec_instr    = '0;
        dec_src1     = '0;
        dec_src2     = '0;
        dec_dst      = '0;
        dec_alu_op   = ALU_NOP;
        dec_imm      = '0;
        dec_regwrite = 1'b0;
        dec_exit     = 1'b0;
        drop         = '0;
        wb_valid     = 1'b0;
        wb_warp_id   = '0;
        wb_reg       = '0;
        oc_stall     = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        reset_state_check();
        single_warp_flow();
        round_robin_order();
        dependency_hold();
        stall_and_drop();
        exit_retire();

        $display("summary: 6 tests, %0d with errors, %0d errors in total",
                 failed_tests, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* instr_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_buffer
    import gpu_ib_pkg::*;
#(
    parameter int NUM_WARPS = 4,
    parameter int WARP_ID_W = $clog2(NUM_WARPS)
) (
    input  logic                 clk,
    input  logic                 reset,

    // decode port
    input  logic                 dec_valid,
    input  logic [WARP_ID_W-1:0] dec_warp_id,
    input  logic [INSTR_W-1:0]   dec_instr,
    input  logic [REG_ID_W:0]    dec_src1,
    input  logic [REG_ID_W:0]    dec_src2,
    input  logic [REG_ID_W:0]    dec_dst,
    input  alu_op_e              dec_alu_op,
    input  logic [IMM_W-1:0]     dec_imm,
    input  logic                 dec_regwrite,
    input  logic                 dec_exit,
    output logic [NUM_WARPS-1:0] fetch_req,

    // branch drop
    input  logic [NUM_WARPS-1:0] drop,

    // writeback clear
    input  logic                 wb_valid,
    input  logic [WARP_ID_W-1:0] wb_warp_id,
    input  logic [REG_ID_W-1:0]  wb_reg,

    // operand collector
    input  logic                 oc_stall,
    output logic                 oc_valid,
    output logic [WARP_ID_W-1:0] oc_warp_id,
    output logic [INSTR_W-1:0]   oc_instr,
    output logic [REG_ID_W:0]    oc_src1,
    output logic [REG_ID_W:0]    oc_src2,
    output logic [REG_ID_W:0]    oc_dst,
    output alu_op_e              oc_alu_op,
    output logic [IMM_W-1:0]     oc_imm,
    output logic                 oc_regwrite,

    // register allocation unit
    output logic                 rau_exit,
    output logic [WARP_ID_W-1:0] rau_exit_warp_id
);

    localparam int RF_W = REG_ID_W + 1;

    logic [NUM_WARPS-1:0]          slot_wr_en;
    logic [NUM_WARPS-1:0]          head_valid;
    logic [NUM_WARPS-1:0]          head_exit;
    logic [NUM_WARPS-1:0]          head_regwrite;
    logic [NUM_WARPS*INSTR_W-1:0]  head_instr_flat;
    logic [NUM_WARPS*RF_W-1:0]     head_src1_flat;
    logic [NUM_WARPS*RF_W-1:0]     head_src2_flat;
    logic [NUM_WARPS*RF_W-1:0]     head_dst_flat;
    logic [NUM_WARPS*4-1:0]        head_alu_op_flat;
    logic [NUM_WARPS*IMM_W-1:0]    head_imm_flat;
    logic [NUM_WARPS-1:0]          dependent;
    logic [NUM_WARPS-1:0]          issue_grant;
    logic [NUM_WARPS-1:0]          exit_grant;

    //////////////////////////////////////////////////
    // per-warp slots
    //////////////////////////////////////////////////

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_slot
        assign slot_wr_en[w] = dec_valid && (dec_warp_id == WARP_ID_W'(w));

        ib_warp_slot u_slot (
            .clk           (clk),
            .reset         (reset),
            .wr_en         (slot_wr_en[w]),
            .wr_instr      (dec_instr),
            .wr_src1       (dec_src1),
            .wr_src2       (dec_src2),
            .wr_dst        (dec_dst),
            .wr_alu_op     (dec_alu_op),
            .wr_imm        (dec_imm),
            .wr_regwrite   (dec_regwrite),
            .wr_exit       (dec_exit),
            .drop          (drop[w]),
            .issue_grant   (issue_grant[w]),
            .exit_grant    (exit_grant[w]),
            .fetch_req     (fetch_req[w]),
            .head_valid    (head_valid[w]),
            .head_exit     (head_exit[w]),
            .head_instr    (head_instr_flat[w*INSTR_W +: INSTR_W]),
            .head_src1     (head_src1_flat[w*RF_W +: RF_W]),
            .head_src2     (head_src2_flat[w*RF_W +: RF_W]),
            .head_dst      (head_dst_flat[w*RF_W +: RF_W]),
            .head_alu_op   (head_alu_op_flat[w*4 +: 4]),
            .head_imm      (head_imm_flat[w*IMM_W +: IMM_W]),
            .head_regwrite (head_regwrite[w])
        );
    end

    ib_scoreboard #(
        .NUM_WARPS (NUM_WARPS),
        .WARP_ID_W (WARP_ID_W)
    ) u_scoreboard (
        .clk            (clk),
        .reset          (reset),
        .head_valid     (head_valid),
        .head_src1_flat (head_src1_flat),
        .head_src2_flat (head_src2_flat),
        .head_dst_flat  (head_dst_flat),
        .head_regwrite  (head_regwrite),
        .issue_grant    (issue_grant),
        .wb_valid       (wb_valid),
        .wb_warp_id     (wb_warp_id),
        .wb_reg         (wb_reg),
        .dependent      (dependent)
    );

    ib_issue_arbiter #(
        .NUM_WARPS (NUM_WARPS)
    ) u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .head_valid  (head_valid),
        .head_exit   (head_exit),
        .dependent   (dependent),
        .oc_stall    (oc_stall),
        .issue_grant (issue_grant),
        .exit_grant  (exit_grant)
    );

    ib_issue_stage #(
        .NUM_WARPS (NUM_WARPS),
        .WARP_ID_W (WARP_ID_W)
    ) u_issue_stage (
        .clk              (clk),
        .reset            (reset),
        .issue_grant      (issue_grant),
        .exit_grant       (exit_grant),
        .head_instr_flat  (head_instr_flat),
        .head_src1_flat   (head_src1_flat),
        .head_src2_flat   (head_src2_flat),
        .head_dst_flat    (head_dst_flat),
        .head_alu_op_flat (head_alu_op_flat),
        .head_imm_flat    (head_imm_flat),
        .head_regwrite    (head_regwrite),
        .oc_valid         (oc_valid),
        .oc_warp_id       (oc_warp_id),
        .oc_instr         (oc_instr),
        .oc_src1          (oc_src1),
        .oc_src2          (oc_src2),
        .oc_dst           (oc_dst),
        .oc_alu_op        (oc_alu_op),
        .oc_imm           (oc_imm),
        .oc_regwrite      (oc_regwrite),
        .rau_exit         (rau_exit),
        .rau_exit_warp_id (rau_exit_warp_id)
    );

endmodule

`default_nettype wire

/* ib_issue_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ib_issue_stage
    import gpu_ib_pkg::*;
#(
    parameter int NUM_WARPS = 4,
    parameter int WARP_ID_W = 2
) (
    input  logic                              clk,
    input  logic                              reset,

    input  logic [NUM_WARPS-1:0]              issue_grant,
    input  logic [NUM_WARPS-1:0]              exit_grant,

    input  logic [NUM_WARPS*INSTR_W-1:0]      head_instr_flat,
    input  logic [NUM_WARPS*(REG_ID_W+1)-1:0] head_src1_flat,
    input  logic [NUM_WARPS*(REG_ID_W+1)-1:0] head_src2_flat,
    input  logic [NUM_WARPS*(REG_ID_W+1)-1:0] head_dst_flat,
    input  logic [NUM_WARPS*4-1:0]            head_alu_op_flat,
    input  logic [NUM_WARPS*IMM_W-1:0]        head_imm_flat,
    input  logic [NUM_WARPS-1:0]              head_regwrite,

    output logic                              oc_valid,
    output logic [WARP_ID_W-1:0]              oc_warp_id,
    output logic [INSTR_W-1:0]                oc_instr,
    output logic [REG_ID_W:0]                 oc_src1,
    output logic [REG_ID_W:0]                 oc_src2,
    output logic [REG_ID_W:0]                 oc_dst,
    output alu_op_e                           oc_alu_op,
    output logic [IMM_W-1:0]                  oc_imm,
    output logic                              oc_regwrite,

    output logic                              rau_exit,
    output logic [WARP_ID_W-1:0]              rau_exit_warp_id
);

    localparam int RF_W = REG_ID_W + 1;

    logic [WARP_ID_W-1:0] issue_id;
    logic [WARP_ID_W-1:0] exit_id;
    logic [INSTR_W-1:0]   sel_instr;
    logic [REG_ID_W:0]    sel_src1;
    logic [REG_ID_W:0]    sel_src2;
    logic [REG_ID_W:0]    sel_dst;
    alu_op_e              sel_alu_op;
    logic [IMM_W-1:0]     sel_imm;
    logic                 sel_regwrite;

    // grant to id and head mux
    always_comb begin
        issue_id     = '0;
        exit_id      = '0;
        sel_instr    = '0;
        sel_src1     = '0;
        sel_src2     = '0;
        sel_dst      = '0;
        sel_alu_op   = ALU_NOP;
        sel_imm      = '0;
        sel_regwrite = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (issue_grant[w]) begin
                issue_id     = WARP_ID_W'(w);
                sel_instr    = head_instr_flat[w*INSTR_W +: INSTR_W];
                sel_src1     = head_src1_flat[w*RF_W +: RF_W];
                sel_src2     = head_src2_flat[w*RF_W +: RF_W];
                sel_dst      = head_dst_flat[w*RF_W +: RF_W];
                sel_alu_op   = alu_op_e'(head_alu_op_flat[w*4 +: 4]);
                sel_imm      = head_imm_flat[w*IMM_W +: IMM_W];
                sel_regwrite = head_regwrite[w];
            end
            if (exit_grant[w]) begin
                exit_id = WARP_ID_W'(w);
            end
        end
    end

    //////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            oc_valid <= 1'b0;
            rau_exit <= 1'b0;
        end else begin
            oc_valid <= |issue_grant;
            rau_exit <= |exit_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (|issue_grant) begin
            oc_warp_id  <= issue_id;
            oc_instr    <= sel_instr;
            oc_src1     <= sel_src1;
            oc_src2     <= sel_src2;
            oc_dst      <= sel_dst;
            oc_alu_op   <= sel_alu_op;
            oc_imm      <= sel_imm;
            oc_regwrite <= sel_regwrite;
        end
        if (|exit_grant) begin
            rau_exit_warp_id <= exit_id;
        end
    end

    // one exit per cycle from the arbiter
    a_exit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(exit_grant));

endmodule

`default_nettype wire

/* ib_issue_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module ib_issue_arbiter #(
    parameter int NUM_WARPS = 4
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic [NUM_WARPS-1:0] head_valid,
    input  logic [NUM_WARPS-1:0] head_exit,
    input  logic [NUM_WARPS-1:0] dependent,
    input  logic                 oc_stall,

    output logic [NUM_WARPS-1:0] issue_grant,
    output logic [NUM_WARPS-1:0] exit_grant
);

    logic [NUM_WARPS-1:0] eligible;
    logic [NUM_WARPS-1:0] rr_mask;
    logic [NUM_WARPS-1:0] masked_req;
    logic [NUM_WARPS-1:0] pick_src;

    assign eligible = head_valid & ~dependent & {NUM_WARPS{~oc_stall}};

    //////////////////////////////////////////////////
    // round-robin issue
    //////////////////////////////////////////////////

    // rr_mask keeps the warps above the last grant
    assign masked_req  = eligible & rr_mask;
    assign pick_src    = (masked_req != '0) ? masked_req : eligible;
    // lowest set bit wins
    assign issue_grant = pick_src & (~pick_src + 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_mask <= '1;
        end else if (issue_grant != '0) begin
            rr_mask <= ~((issue_grant << 1) - 1'b1);
        end
    end

    // exits are not held off by stall, fixed priority
    assign exit_grant = head_exit & (~head_exit + 1'b1);

    a_issue_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(issue_grant));

    a_issue_eligible: assert property (@(posedge clk) disable iff (reset)
        (issue_grant & ~(head_valid & ~dependent)) == '0);

    a_no_issue_in_stall: assert property (@(posedge clk) disable iff (reset)
        oc_stall |-> (issue_grant == '0));

endmodule

`default_nettype wire

/* ib_scoreboard.sv */
`timescale 1ns/10ps
`default_nettype none

module ib_scoreboard
    import gpu_ib_pkg::*;
#(
    parameter int NUM_WARPS = 4,
    parameter int WARP_ID_W = 2
) (
    input  logic                            clk,
    input  logic                            reset,

    input  logic [NUM_WARPS-1:0]            head_valid,
    input  logic [NUM_WARPS*(REG_ID_W+1)-1:0] head_src1_flat,
    input  logic [NUM_WARPS*(REG_ID_W+1)-1:0] head_src2_flat,
    input  logic [NUM_WARPS*(REG_ID_W+1)-1:0] head_dst_flat,
    input  logic [NUM_WARPS-1:0]            head_regwrite,

    input  logic [NUM_WARPS-1:0]            issue_grant,

    input  logic                            wb_valid,
    input  logic [WARP_ID_W-1:0]            wb_warp_id,
    input  logic [REG_ID_W-1:0]             wb_reg,

    output logic [NUM_WARPS-1:0]            dependent
);

    localparam int RF_W = REG_ID_W + 1;

    logic [NUM_REGS-1:0] pending [NUM_WARPS];

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        logic [REG_ID_W:0]   src1;
        logic [REG_ID_W:0]   src2;
        logic [REG_ID_W:0]   dst;
        logic                hit_src1;
        logic                hit_src2;
        logic                hit_dst;
        logic [NUM_REGS-1:0] pend_next;

        assign src1 = head_src1_flat[w*RF_W +: RF_W];
        assign src2 = head_src2_flat[w*RF_W +: RF_W];
        assign dst  = head_dst_flat[w*RF_W +: RF_W];

        // msb of each field is its valid bit
        assign hit_src1 = src1[REG_ID_W] && pending[w][src1[REG_ID_W-1:0]];
        assign hit_src2 = src2[REG_ID_W] && pending[w][src2[REG_ID_W-1:0]];
        assign hit_dst  = dst[REG_ID_W] && pending[w][dst[REG_ID_W-1:0]];

        assign dependent[w] = head_valid[w] && (hit_src1 || hit_src2 || hit_dst);

        // writeback clear first, then set from the issuing head
        always_comb begin
            pend_next = pending[w];
            if (wb_valid && (wb_warp_id == WARP_ID_W'(w))) begin
                pend_next[wb_reg] = 1'b0;
            end
            if (issue_grant[w] && head_regwrite[w] && dst[REG_ID_W]) begin
                pend_next[dst[REG_ID_W-1:0]] = 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                pending[w] <= '0;
            end else begin
                pending[w] <= pend_next;
            end
        end
    end

    // writeback only for a register that was issued as a destination
    a_wb_clears_pending: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> pending[wb_warp_id][wb_reg]);

endmodule

`default_nettype wire

/* ib_warp_slot.sv */
`timescale 1ns/10ps
`default_nettype none

module ib_warp_slot
    import gpu_ib_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    // decode write, already qualified by warp id
    input  logic                wr_en,
    input  logic [INSTR_W-1:0]  wr_instr,
    input  logic [REG_ID_W:0]   wr_src1,
    input  logic [REG_ID_W:0]   wr_src2,
    input  logic [REG_ID_W:0]   wr_dst,
    input  alu_op_e             wr_alu_op,
    input  logic [IMM_W-1:0]    wr_imm,
    input  logic                wr_regwrite,
    input  logic                wr_exit,

    input  logic                drop,
    input  logic                issue_grant,
    input  logic                exit_grant,

    output logic                fetch_req,

    output logic                head_valid,
    output logic                head_exit,
    output logic [INSTR_W-1:0]  head_instr,
    output logic [REG_ID_W:0]   head_src1,
    output logic [REG_ID_W:0]   head_src2,
    output logic [REG_ID_W:0]   head_dst,
    output alu_op_e             head_alu_op,
    output logic [IMM_W-1:0]    head_imm,
    output logic                head_regwrite
);

    logic [INSTR_W-1:0] q_instr    [2];
    logic [REG_ID_W:0]  q_src1     [2];
    logic [REG_ID_W:0]  q_src2     [2];
    logic [REG_ID_W:0]  q_dst      [2];
    alu_op_e            q_alu_op   [2];
    logic [IMM_W-1:0]   q_imm      [2];
    logic               q_regwrite [2];
    logic               q_exit     [2];

    logic        rd_ptr;
    logic        wr_ptr;
    logic [1:0]  count;
    logic        pop;
    warp_state_e state;

    assign pop       = issue_grant || exit_grant;
    assign fetch_req = (count < 2'd2) && (state == WARP_ACTIVE);

    //////////////////////////////////////////////////
    // queue control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= 1'b0;
            wr_ptr <= 1'b0;
            count  <= 2'd0;
            state  <= WARP_ACTIVE;
        end else begin
            if (exit_grant) begin
                state <= WARP_EXITED;
            end
            // flush on branch drop or when the warp retires
            if (drop || exit_grant) begin
                count  <= 2'd0;
                rd_ptr <= wr_ptr;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                unique case ({wr_en, pop})
                    2'b10:   count <= count + 2'd1;
                    2'b01:   count <= count - 2'd1;
                    default: count <= count;
                endcase
            end
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            q_instr[wr_ptr]    <= wr_instr;
            q_src1[wr_ptr]     <= wr_src1;
            q_src2[wr_ptr]     <= wr_src2;
            q_dst[wr_ptr]      <= wr_dst;
            q_alu_op[wr_ptr]   <= wr_alu_op;
            q_imm[wr_ptr]      <= wr_imm;
            q_regwrite[wr_ptr] <= wr_regwrite;
            q_exit[wr_ptr]     <= wr_exit;
        end
    end

    // head view, exit entries go to the exit path only
    assign head_valid    = (count != 2'd0) && !q_exit[rd_ptr];
    assign head_exit     = (count != 2'd0) && q_exit[rd_ptr];
    assign head_instr    = q_instr[rd_ptr];
    assign head_src1     = q_src1[rd_ptr];
    assign head_src2     = q_src2[rd_ptr];
    assign head_dst      = q_dst[rd_ptr];
    assign head_alu_op   = q_alu_op[rd_ptr];
    assign head_imm      = q_imm[rd_ptr];
    assign head_regwrite = q_regwrite[rd_ptr];

    // decoder must honour fetch_req
    a_no_write_when_blocked: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (count != 2'd2) && (state == WARP_ACTIVE));

    a_single_grant: assert property (@(posedge clk) disable iff (reset)
        !(issue_grant && exit_grant));

endmodule

`default_nettype wire

/* gpu_ib_pkg.sv */
`default_nettype none

package gpu_ib_pkg;

    // register ID width, port fields carry one extra valid bit on top
    parameter int REG_ID_W = 5;
    parameter int INSTR_W  = 32;
    parameter int IMM_W    = 16;
    parameter int NUM_REGS = 32;

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,
        ALU_SRL = 4'h6,
        ALU_SLT = 4'h7,
        ALU_MUL = 4'h8,
        ALU_NOP = 4'hf
    } alu_op_e;

    typedef enum logic {
        WARP_ACTIVE = 1'b0,
        WARP_EXITED = 1'b1
    } warp_state_e;

endpackage

`default_nettype wire
